/* dircc_cfg.svh */
`ifndef DIRCC_CFG_SVH
`define DIRCC_CFG_SVH

`define DIRCC_NUM_DEVICES       8
`define DIRCC_DEV_ADDR_W        16
`define DIRCC_PACKET_W          96
`define DIRCC_USER_STATE_BYTES  4
`define DIRCC_STATE_W           48

// Packet layout.
`define DIRCC_PKT_DST_HI        95
`define DIRCC_PKT_DST_LO        80
`define DIRCC_PKT_SRC_HI        79
`define DIRCC_PKT_SRC_LO        64
`define DIRCC_PKT_TICK_HI       63
`define DIRCC_PKT_TICK_LO       0

// Device state holds framework state, framework extra and user state.
`define DIRCC_ST_FW_HI          47
`define DIRCC_ST_FW_LO          40
`define DIRCC_ST_EXTRA_HI       39
`define DIRCC_ST_EXTRA_LO       32
`define DIRCC_ST_USER_HI        31
`define DIRCC_ST_USER_LO        0

`define DIRCC_US_COUNT_HI       15
`define DIRCC_US_COUNT_LO       0
`define DIRCC_US_RTS_HI         31
`define DIRCC_US_RTS_LO         16 // Only this bit of the field is used.

`endif

/* dircc_types_pkg.sv */
`include "dircc_cfg.svh"

package dircc_types_pkg;

    typedef logic [`DIRCC_DEV_ADDR_W-1:0] dev_addr_t;

    typedef logic [`DIRCC_PACKET_W-1:0] packet_t;

    typedef logic [`DIRCC_STATE_W-1:0] device_state_t;

    typedef logic [8*`DIRCC_USER_STATE_BYTES-1:0] user_state_t;

    localparam int ram_index_w = $clog2(`DIRCC_NUM_DEVICES);

    typedef logic [ram_index_w-1:0] ram_index_t;

    // Receive path runs read_rx..write_rx, send path read_scan..write_tx.
    typedef enum logic [2:0] {
        idle,
        read_rx,
        receive,
        write_rx,
        read_scan,
        send,
        write_tx
    } ctrl_state_e;

endpackage : dircc_types_pkg

/* dircc_state_ram.sv */
`timescale 1ns/1ps
`include "dircc_cfg.svh"

module dircc_state_ram (
    input  logic                           clk,
    input  logic                           reset_n,

    input  logic                           rd_en,
    input  dircc_types_pkg::ram_index_t    rd_index,
    output dircc_types_pkg::device_state_t rd_state,

    input  logic                           wr_en,
    input  dircc_types_pkg::ram_index_t    wr_index,
    input  dircc_types_pkg::device_state_t wr_state
);

    dircc_types_pkg::device_state_t mem [`DIRCC_NUM_DEVICES];

    // All devices start with a zero state.
    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `DIRCC_NUM_DEVICES; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (wr_en) begin
                mem[wr_index] <= wr_state;
            end
        end
    end

    // Registered read returns old data on a same-index write.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_state <= mem[rd_index];
        end
    end

endmodule : dircc_state_ram

/* dircc_receive_handler.sv */
`timescale 1ns/1ps
`include "dircc_cfg.svh"

module dircc_receive_handler (
    input  logic                           clk,
    input  logic                           reset_n,

    input  dircc_types_pkg::dev_addr_t     address,

    input  logic                           receive_done,
    input  dircc_types_pkg::packet_t       packet_in,
    input  logic                           packet_in_valid,
    output logic                           packet_handled,

    input  dircc_types_pkg::device_state_t read_state,

    output dircc_types_pkg::device_state_t write_state,
    output logic                           write_state_valid
);

    dircc_types_pkg::user_state_t old_user;
    dircc_types_pkg::user_state_t new_user;
    dircc_types_pkg::dev_addr_t   dest;
    logic                         handle;

    assign old_user = read_state[`DIRCC_ST_USER_HI:`DIRCC_ST_USER_LO];
    assign dest     = packet_in[`DIRCC_PKT_DST_HI:`DIRCC_PKT_DST_LO];
    assign handle   = receive_done && packet_in_valid;

    // Framework fields are not touched by the tick handler.
    assign write_state = {read_state[`DIRCC_ST_FW_HI:`DIRCC_ST_FW_LO],
                          read_state[`DIRCC_ST_EXTRA_HI:`DIRCC_ST_EXTRA_LO],
                          new_user};

    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            write_state_valid <= 1'b0;
            packet_handled    <= 1'b0;
        end else begin
            write_state_valid <= handle;
            packet_handled    <= handle;
        end
    end

    always_ff @(posedge clk) begin
        if (handle) begin
            if (dest == address) begin
                new_user <= old_user;
                new_user[`DIRCC_US_COUNT_HI:`DIRCC_US_COUNT_LO] <=
                    old_user[`DIRCC_US_COUNT_HI:`DIRCC_US_COUNT_LO] + 1'b1; // Wraps at 16 bits.
                new_user[`DIRCC_US_RTS_HI:`DIRCC_US_RTS_LO] <= 16'd1;
            end else begin
                new_user <= old_user; // A foreign packet keeps the state as is.
            end
        end
    end

endmodule : dircc_receive_handler

/* dircc_send_handler.sv */
`timescale 1ns/1ps
`include "dircc_cfg.svh"

module dircc_send_handler (
    input  logic                           clk,
    input  logic                           reset_n,

    input  logic                           send_start,
    input  dircc_types_pkg::dev_addr_t     address,
    input  dircc_types_pkg::device_state_t read_state,

    output dircc_types_pkg::packet_t       pkt_out,
    output logic                           pkt_out_valid,
    input  logic                           pkt_out_ready,

    output logic                           send_done,
    output dircc_types_pkg::device_state_t write_state
);

    dircc_types_pkg::user_state_t user;
    dircc_types_pkg::dev_addr_t   next_dev;
    logic [`DIRCC_PKT_TICK_HI-`DIRCC_PKT_TICK_LO:0] tick;

    assign user = read_state[`DIRCC_ST_USER_HI:`DIRCC_ST_USER_LO];

    // Ring neighbour inside the node.
    assign next_dev = dircc_types_pkg::dev_addr_t'((address + 1'b1) % `DIRCC_NUM_DEVICES);

    assign tick = {{(`DIRCC_PKT_TICK_HI - `DIRCC_PKT_TICK_LO + 1 -
                     (`DIRCC_US_COUNT_HI - `DIRCC_US_COUNT_LO + 1)){1'b0}},
                   user[`DIRCC_US_COUNT_HI:`DIRCC_US_COUNT_LO]};

    assign send_done = pkt_out_valid && pkt_out_ready;

    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            pkt_out_valid <= 1'b0;
        end else begin
            if (send_start) begin
                pkt_out_valid <= 1'b1;
            end else if (send_done) begin
                pkt_out_valid <= 1'b0;
            end
        end
    end

    // Packet and write-back state stay put until the controller is done.
    always_ff @(posedge clk) begin
        if (send_start) begin
            pkt_out[`DIRCC_PKT_DST_HI:`DIRCC_PKT_DST_LO]   <= next_dev;
            pkt_out[`DIRCC_PKT_SRC_HI:`DIRCC_PKT_SRC_LO]   <= address;
            pkt_out[`DIRCC_PKT_TICK_HI:`DIRCC_PKT_TICK_LO] <= tick;

            write_state <= read_state;
            write_state[`DIRCC_ST_USER_LO + `DIRCC_US_RTS_HI:
                        `DIRCC_ST_USER_LO + `DIRCC_US_RTS_LO] <= '0; // Flag cleared.
        end
    end

endmodule : dircc_send_handler

/* dircc_device_controller.sv */
`timescale 1ns/1ps
`include "dircc_cfg.svh"

module dircc_device_controller (
    input  logic                           clk,
    input  logic                           reset_n,

    input  dircc_types_pkg::packet_t       pkt_in,
    input  logic                           pkt_in_valid,
    output logic                           pkt_in_ready,

    output logic                           rd_en,
    output dircc_types_pkg::ram_index_t    rd_index,
    input  dircc_types_pkg::device_state_t rd_state,
    output logic                           wr_en,
    output dircc_types_pkg::ram_index_t    wr_index,
    output dircc_types_pkg::device_state_t wr_state,

    output logic                           receive_done,
    output dircc_types_pkg::packet_t       packet_reg,
    output logic                           packet_reg_valid,
    output dircc_types_pkg::dev_addr_t     device_address,
    input  logic                           write_state_valid,
    input  dircc_types_pkg::device_state_t rx_write_state,

    output logic                           send_start,
    input  logic                           send_done,
    input  dircc_types_pkg::device_state_t tx_write_state
);

    dircc_types_pkg::ctrl_state_e state;
    dircc_types_pkg::ram_index_t  rx_index;
    dircc_types_pkg::ram_index_t  scan_index;
    dircc_types_pkg::ram_index_t  cur_index;
    logic                         running; // Low for the first cycle after reset.
    logic                         send_busy;
    logic                         rts;
    logic                         rx_path;

    assign rx_index = dircc_types_pkg::ram_index_t'(
        packet_reg[`DIRCC_PKT_DST_HI:`DIRCC_PKT_DST_LO]);
    assign rts      = rd_state[`DIRCC_ST_USER_LO + `DIRCC_US_RTS_LO];

    assign rx_path = (state == dircc_types_pkg::read_rx) ||
                     (state == dircc_types_pkg::receive) ||
                     (state == dircc_types_pkg::write_rx);
    assign cur_index = rx_path ? rx_index : scan_index;

    assign pkt_in_ready   = running && (state == dircc_types_pkg::idle);
    assign rd_en          = (state == dircc_types_pkg::read_rx) ||
                            (state == dircc_types_pkg::read_scan);
    assign rd_index       = cur_index;
    assign wr_en          = ((state == dircc_types_pkg::write_rx) && write_state_valid) ||
                            (state == dircc_types_pkg::write_tx);
    assign wr_index       = cur_index;
    assign wr_state       = rx_path ? rx_write_state : tx_write_state;
    assign receive_done   = (state == dircc_types_pkg::receive);
    assign device_address = dircc_types_pkg::dev_addr_t'(cur_index);
    assign send_start     = (state == dircc_types_pkg::send) && !send_busy && rts;

    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            state            <= dircc_types_pkg::idle;
            running          <= 1'b0;
            send_busy        <= 1'b0;
            scan_index       <= '0;
            packet_reg_valid <= 1'b0;
        end else begin
            running <= 1'b1;
            case (state)
                dircc_types_pkg::idle: begin
                    if (pkt_in_valid && pkt_in_ready) begin
                        state            <= dircc_types_pkg::read_rx;
                        packet_reg_valid <= 1'b1;
                    end else if (running) begin
                        state <= dircc_types_pkg::read_scan; // Scan when nothing is waiting.
                    end
                end
                dircc_types_pkg::read_rx:   state <= dircc_types_pkg::receive;
                dircc_types_pkg::receive:   state <= dircc_types_pkg::write_rx;
                dircc_types_pkg::write_rx: begin
                    state            <= dircc_types_pkg::idle;
                    packet_reg_valid <= 1'b0;
                end
                dircc_types_pkg::read_scan: state <= dircc_types_pkg::send;
                dircc_types_pkg::send: begin
                    if (send_busy) begin
                        if (send_done) begin
                            state     <= dircc_types_pkg::write_tx;
                            send_busy <= 1'b0;
                        end
                    end else if (rts) begin
                        send_busy <= 1'b1;
                    end else begin
                        state      <= dircc_types_pkg::idle;
                        scan_index <= scan_index + 1'b1;
                    end
                end
                dircc_types_pkg::write_tx: begin
                    state      <= dircc_types_pkg::idle;
                    scan_index <= scan_index + 1'b1;
                end
                default: state <= dircc_types_pkg::idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pkt_in_valid && pkt_in_ready) begin
            packet_reg <= pkt_in;
        end
    end

endmodule : dircc_device_controller

/* dircc_node.sv */
`timescale 1ns/1ps

module dircc_node (
    input  logic                     clk,
    input  logic                     reset_n,

    input  dircc_types_pkg::packet_t pkt_in,
    input  logic                     pkt_in_valid,
    output logic                     pkt_in_ready,

    output dircc_types_pkg::packet_t pkt_out,
    output logic                     pkt_out_valid,
    input  logic                     pkt_out_ready
);

    logic                           rd_en;
    logic                           wr_en;
    dircc_types_pkg::ram_index_t    rd_index;
    dircc_types_pkg::ram_index_t    wr_index;
    dircc_types_pkg::device_state_t rd_state;
    dircc_types_pkg::device_state_t wr_state;

    logic                           receive_done;
    dircc_types_pkg::packet_t       packet_reg;
    logic                           packet_reg_valid;
    dircc_types_pkg::dev_addr_t     device_address;
    logic                           rx_write_state_valid;
    dircc_types_pkg::device_state_t rx_write_state;

    logic                           send_start;
    logic                           send_done;
    dircc_types_pkg::device_state_t tx_write_state;

    dircc_state_ram u_state_ram (
        .clk      (clk),
        .reset_n  (reset_n),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .rd_state (rd_state),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_state (wr_state)
    );

    dircc_device_controller u_controller (
        .clk               (clk),
        .reset_n           (reset_n),
        .pkt_in            (pkt_in),
        .pkt_in_valid      (pkt_in_valid),
        .pkt_in_ready      (pkt_in_ready),
        .rd_en             (rd_en),
        .rd_index          (rd_index),
        .rd_state          (rd_state),
        .wr_en             (wr_en),
        .wr_index          (wr_index),
        .wr_state          (wr_state),
        .receive_done      (receive_done),
        .packet_reg        (packet_reg),
        .packet_reg_valid  (packet_reg_valid),
        .device_address    (device_address),
        .write_state_valid (rx_write_state_valid),
        .rx_write_state    (rx_write_state),
        .send_start        (send_start),
        .send_done         (send_done),
        .tx_write_state    (tx_write_state)
    );

    dircc_receive_handler u_receive_handler (
        .clk               (clk),
        .reset_n           (reset_n),
        .address           (device_address),
        .receive_done      (receive_done),
        .packet_in         (packet_reg),
        .packet_in_valid   (packet_reg_valid),
        .packet_handled    (),
        .read_state        (rd_state),
        .write_state       (rx_write_state),
        .write_state_valid (rx_write_state_valid)
    );

    dircc_send_handler u_send_handler (
        .clk           (clk),
        .reset_n       (reset_n),
        .send_start    (send_start),
        .address       (device_address),
        .read_state    (rd_state),
        .pkt_out       (pkt_out),
        .pkt_out_valid (pkt_out_valid),
        .pkt_out_ready (pkt_out_ready),
        .send_done     (send_done),
        .write_state   (tx_write_state)
    );

endmodule : dircc_node

/* dircc_node_checker.sv */
`timescale 1ns/1ps
`include "dircc_cfg.svh"

module dircc_node_checker (
    input  logic                     clk,
    input  logic                     reset_n,
    input  dircc_types_pkg::packet_t pkt_in,
    input  logic                     pkt_in_valid,
    input  logic                     pkt_in_ready,
    input  dircc_types_pkg::packet_t pkt_out,
    input  logic                     pkt_out_valid,
    input  logic                     pkt_out_ready
);

    logic [`DIRCC_NUM_DEVICES-1:0] seen; // Devices that have received a tick.
    dircc_types_pkg::dev_addr_t    in_dst;
    dircc_types_pkg::dev_addr_t    out_src;
    int unsigned                   fails = 0;

    assign in_dst  = pkt_in[`DIRCC_PKT_DST_HI:`DIRCC_PKT_DST_LO];
    assign out_src = pkt_out[`DIRCC_PKT_SRC_HI:`DIRCC_PKT_SRC_LO];

    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            seen <= '0;
        end else if (pkt_in_valid && pkt_in_ready && in_dst < `DIRCC_NUM_DEVICES) begin
            seen[dircc_types_pkg::ram_index_t'(in_dst)] <= 1'b1;
        end
    end

    out_hold: assert property (@(posedge clk) disable iff (!reset_n)
        pkt_out_valid && !pkt_out_ready |=> pkt_out_valid && $stable(pkt_out))
        else begin
            fails++;
            $error("output packet changed or dropped while stalled");
        end

    reset_quiet: assert property (@(posedge clk)
        !reset_n |-> !pkt_out_valid && !pkt_in_ready)
        else begin
            fails++;
            $error("handshake signal high during reset");
        end

    out_after_in: assert property (@(posedge clk) disable iff (!reset_n)
        pkt_out_valid |-> out_src < `DIRCC_NUM_DEVICES &&
                          seen[dircc_types_pkg::ram_index_t'(out_src)])
        else begin
            fails++;
            $error("output from a device that never received a tick");
        end

endmodule : dircc_node_checker

/* dircc_node_scoreboard.sv */
`timescale 1ns/1ps
`include "dircc_cfg.svh"

module dircc_node_scoreboard (
    input  logic                        clk,
    input  logic                        reset_n,
    input  dircc_types_pkg::packet_t    pkt_in,
    input  logic                        pkt_in_valid,
    input  logic                        pkt_in_ready,
    input  dircc_types_pkg::packet_t    pkt_out,
    input  logic                        pkt_out_valid,
    input  logic                        pkt_out_ready,
    input  logic                        check_req,
    input  logic                        report,
    input  int                          test_num,
    input  dircc_types_pkg::ram_index_t exp_dev,
    input  logic [15:0]                 exp_count,
    output logic                        pending,
    output int                          errors,
    output int                          checks
);

    logic [15:0]                   count [`DIRCC_NUM_DEVICES];
    logic [15:0]                   last_tick [`DIRCC_NUM_DEVICES];
    logic [`DIRCC_NUM_DEVICES-1:0] rts;
    int                            test_base;
    dircc_types_pkg::dev_addr_t    in_dst;
    dircc_types_pkg::dev_addr_t    out_src;
    dircc_types_pkg::dev_addr_t    out_dst;
    dircc_types_pkg::ram_index_t   src_idx;
    logic [63:0]                   out_tick;

    assign in_dst   = pkt_in[`DIRCC_PKT_DST_HI:`DIRCC_PKT_DST_LO];
    assign out_src  = pkt_out[`DIRCC_PKT_SRC_HI:`DIRCC_PKT_SRC_LO];
    assign out_dst  = pkt_out[`DIRCC_PKT_DST_HI:`DIRCC_PKT_DST_LO];
    assign out_tick = pkt_out[`DIRCC_PKT_TICK_HI:`DIRCC_PKT_TICK_LO];
    assign src_idx  = dircc_types_pkg::ram_index_t'(out_src);
    assign pending  = |rts;

    initial begin
        errors    = 0;
        checks    = 0;
        test_base = 0;
    end

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        errors++;
        $display("mismatch at %0t: %s expected %0d, actual %0d", $time, name, expected, actual);
    endtask

    task automatic check_output();
        checks++;
        if (out_src >= `DIRCC_NUM_DEVICES || !rts[src_idx]) begin
            errors++;
            $display("error at %0t: device %0d sent a tick with nothing pending", $time, out_src);
        end
        if (out_dst != (out_src + 16'd1) % `DIRCC_NUM_DEVICES) begin
            report_mismatch("pkt_out.dst", (out_src + 16'd1) % `DIRCC_NUM_DEVICES, out_dst);
        end
        if (out_tick != {48'h0, count[src_idx]}) begin
            report_mismatch("pkt_out.tick", count[src_idx], out_tick);
        end
        rts[src_idx]       <= 1'b0;
        last_tick[src_idx] <= out_tick[15:0];
    endtask

    task automatic finish_test();
        if (last_tick[exp_dev] != exp_count) begin
            report_mismatch($sformatf("last_tick[%0d]", exp_dev), exp_count, last_tick[exp_dev]);
        end
        if (report) begin
            if (errors == test_base) begin
                $display("test %0d: pass", test_num);
            end else begin
                $display("test %0d: fail with %0d errors", test_num, errors - test_base);
            end
            test_base = errors;
        end
    endtask

    // Handshakes are seen half a cycle before the edge that completes them.
    always @(negedge clk) begin
        if (!reset_n) begin
            rts <= '0;
            for (int i = 0; i < `DIRCC_NUM_DEVICES; i++) begin
                count[i]     <= '0;
                last_tick[i] <= '0;
            end
        end else begin
            if (pkt_out_valid && pkt_out_ready) begin
                check_output();
            end
            if (pkt_in_valid && pkt_in_ready && in_dst < `DIRCC_NUM_DEVICES) begin
                count[dircc_types_pkg::ram_index_t'(in_dst)] <=
                    count[dircc_types_pkg::ram_index_t'(in_dst)] + 16'd1;
                rts[dircc_types_pkg::ram_index_t'(in_dst)] <= 1'b1;
            end
            if (check_req) begin
                finish_test();
            end
        end
    end

endmodule : dircc_node_scoreboard

/* dircc_node_tb.sv */
`timescale 1ns/1ps
`include "dircc_cfg.svh"

module dircc_node_tb;

    localparam int num_entries    = 17;
    localparam int timeout_cycles = num_entries * 40 + 200;
    localparam int quiet_cycles   = 50;

    localparam int bp_none   = 0;
    localparam int bp_stall  = 1;
    localparam int bp_random = 2;

    localparam int wait_none  = 0; // Next entry follows at once.
    localparam int wait_valid = 1; // Until an output packet is offered.
    localparam int wait_drain = 2; // Until no tick is pending.
    localparam int wait_quiet = 3;

    typedef struct {
        int          test;
        bit          send;
        logic [15:0] dest;
        logic [63:0] payload;
        int          bp;
        int          stall;
        int          wmode;
        int          exp_count;
    } entry_t;

    logic                        clk;
    logic                        reset_n;
    dircc_types_pkg::packet_t    pkt_in;
    logic                        pkt_in_valid;
    logic                        pkt_in_ready;
    dircc_types_pkg::packet_t    pkt_out;
    logic                        pkt_out_valid;
    logic                        pkt_out_ready;

    entry_t                      tbl [num_entries];
    int                          n_added = 0;
    int                          bp_mode = bp_none;
    int                          stall_len = 0;
    int                          stall_cnt = 0;
    logic [31:0]                 rnd_state = 32'h07ab2d77;
    int                          cycles;
    int                          tests_run = 0;
    logic                        check_req;
    logic                        report;
    int                          test_num;
    dircc_types_pkg::ram_index_t exp_dev;
    logic [15:0]                 exp_count;
    logic                        pending;
    int                          errors;
    int                          checks;

    dircc_node u_dircc_node (
        .clk           (clk),
        .reset_n       (reset_n),
        .pkt_in        (pkt_in),
        .pkt_in_valid  (pkt_in_valid),
        .pkt_in_ready  (pkt_in_ready),
        .pkt_out       (pkt_out),
        .pkt_out_valid (pkt_out_valid),
        .pkt_out_ready (pkt_out_ready)
    );

    dircc_node_scoreboard u_scoreboard (
        .clk           (clk),
        .reset_n       (reset_n),
        .pkt_in        (pkt_in),
        .pkt_in_valid  (pkt_in_valid),
        .pkt_in_ready  (pkt_in_ready),
        .pkt_out       (pkt_out),
        .pkt_out_valid (pkt_out_valid),
        .pkt_out_ready (pkt_out_ready),
        .check_req     (check_req),
        .report        (report),
        .test_num      (test_num),
        .exp_dev       (exp_dev),
        .exp_count     (exp_count),
        .pending       (pending),
        .errors        (errors),
        .checks        (checks)
    );

    bind dircc_node dircc_node_checker u_checker (
        .clk           (clk),
        .reset_n       (reset_n),
        .pkt_in        (pkt_in),
        .pkt_in_valid  (pkt_in_valid),
        .pkt_in_ready  (pkt_in_ready),
        .pkt_out       (pkt_out),
        .pkt_out_valid (pkt_out_valid),
        .pkt_out_ready (pkt_out_ready)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic add_entry(input int test, input bit send, input logic [15:0] dest,
                             input int bp, input int stall, input int wmode, input int exp_count);
        tbl[n_added] = '{test, send, dest, {32'(test), 32'(n_added)}, bp, stall, wmode, exp_count};
        n_added++;
    endtask

    task automatic build_table();
        add_entry(1, 1'b0, 16'd0, bp_none, 0, wait_quiet, 0);
        add_entry(2, 1'b1, 16'd3, bp_none, 0, wait_drain, 1);
        for (int k = 1; k <= 3; k++) begin
            add_entry(3, 1'b1, 16'd5, bp_none, 0, wait_drain, k);
        end
        add_entry(4, 1'b1, 16'd2, bp_stall, 6, wait_valid, 0);
        add_entry(4, 1'b1, 16'd2, bp_stall, 6, wait_none, 0); // Held while the tick stalls.
        add_entry(4, 1'b1, 16'd2, bp_stall, 6, wait_drain, 3);
        for (int d = 0; d < 7; d++) begin
            add_entry(5, 1'b1, 16'(d), bp_random, 0, wait_none, 0);
        end
        add_entry(5, 1'b1, 16'd7, bp_random, 0, wait_drain, 1);
        add_entry(6, 1'b1, 16'h0104, bp_none, 0, wait_quiet, 1); // Not a local device.
    endtask

    task automatic send_packet(input logic [15:0] dest, input logic [63:0] payload);
        @(posedge clk);
        pkt_in       <= {dest, 16'h0000, payload};
        pkt_in_valid <= 1'b1;
        do @(negedge clk); while (!pkt_in_ready);
        @(posedge clk);
        pkt_in_valid <= 1'b0;
    endtask

    task automatic run_entry(input int i);
        entry_t e;
        bit     last;
        e    = tbl[i];
        last = 1'b1;
        if (i < num_entries - 1) begin
            last = (tbl[i + 1].test != e.test);
        end
        @(posedge clk);
        bp_mode   <= e.bp;
        stall_len <= e.stall;
        if (e.send) begin
            send_packet(e.dest, e.payload);
        end
        case (e.wmode)
            wait_valid: do @(negedge clk); while (!pkt_out_valid);
            wait_drain: do @(negedge clk); while (pending || pkt_out_valid);
            wait_quiet: repeat (quiet_cycles) @(negedge clk);
            default: ;
        endcase
        if (e.wmode == wait_drain || e.wmode == wait_quiet) begin
            @(posedge clk);
            test_num  <= e.test;
            exp_dev   <= dircc_types_pkg::ram_index_t'(e.dest);
            exp_count <= 16'(e.exp_count);
            report    <= last;
            check_req <= 1'b1;
            @(posedge clk);
            check_req <= 1'b0;
            if (last) begin
                tests_run++;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Stall length counts cycles of an offered but unaccepted packet.
    always @(negedge clk) begin
        if (pkt_out_valid && pkt_out_ready) begin
            stall_cnt <= 0;
        end else if (pkt_out_valid) begin
            stall_cnt <= stall_cnt + 1;
        end
    end

    always @(posedge clk) begin
        rnd_state <= lcg_next(rnd_state);
        if (bp_mode == bp_stall) begin
            pkt_out_ready <= (stall_cnt >= stall_len);
        end else if (bp_mode == bp_random) begin
            pkt_out_ready <= rnd_state[19];
        end else begin
            pkt_out_ready <= 1'b1;
        end
    end

    initial begin
        cycles = 0;
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the DUT did not finish within %0d cycles", timeout_cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        int total;
        reset_n       = 1'b0;
        pkt_in        = '0;
        pkt_in_valid  = 1'b0;
        pkt_out_ready = 1'b1;
        check_req     = 1'b0;
        report        = 1'b0;
        test_num      = 0;
        exp_dev       = '0;
        exp_count     = '0;
        build_table();
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;
        for (int i = 0; i < num_entries; i++) begin
            run_entry(i);
        end
        repeat (2) @(posedge clk);
        total = errors + u_dircc_node.u_checker.fails;
        $display("tests %0d, output checks %0d, errors %0d, assertion failures %0d",
                 tests_run, checks, errors, u_dircc_node.u_checker.fails);
        if (total == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule : dircc_node_tb

/* dircc_node.f */
+incdir+.
dircc_types_pkg.sv
dircc_state_ram.sv
dircc_receive_handler.sv
dircc_send_handler.sv
dircc_device_controller.sv
dircc_node.sv
dircc_node_checker.sv
dircc_node_scoreboard.sv
dircc_node_tb.sv

/* Bender.yml */
package:
  name: dircc_node

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - dircc_types_pkg.sv
      - dircc_state_ram.sv
      - dircc_receive_handler.sv
      - dircc_send_handler.sv
      - dircc_device_controller.sv
      - dircc_node.sv
  - target: test
    include_dirs:
      - .
    files:
      - dircc_node_checker.sv
      - dircc_node_scoreboard.sv
      - dircc_node_tb.sv
